//--- sim/pong_trace.txt
# name sw[2:0] frames keys paddle_x puck1_x puck1_y puck2_x puck2_y
# keys: one letter per frame, R right, L left, B both, N none, the last letter holds
start_left_wall      2 6   LLRRB   13  86  54  40  60
start_right_wall     6 5   RRLRN   144 85  55  40  60
run_right_to_limit   0 40  R       145 120 20  40  60
run_left_to_limit    0 40  L       5   120 20  40  60
two_pucks            5 40  N       75  120 20  10  20
paddle_bounce        0 166 LLLLLLN 63  62  112 40  60
puck1_miss           0 164 N       75  64  114 40  60
puck2_miss           1 164 LLLLLLN 63  64  114 134 114

//--- verilog.f
hdl/pong_pkg.sv
hdl/paddle_control.sv
hdl/puck_motion.sv
hdl/draw_sequencer.sv
hdl/pong_top.sv
sim/tb_pong.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pong -f verilog.f -o tb_pong \
        && ./obj_dir/tb_pong > sim.log 2>&1 \
        || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

//--- sim/tb_pong.sv
`timescale 1ns/10ps

// testbench for the paddle game, every plotted pixel is checked against a model
module tb_pong;

        localparam int LOOP_SPEED   = 20;
        localparam int MAX_TESTS    = 16;
        // clear raster plus the three border lines and their entry cycles, rounded up
        localparam int SETUP_CYCLES = 20000;

        // ==================================================
        // playfield as the frame buffer sees it
        // ==================================================
        localparam int BG         = 0;
        localparam int PUCK       = 5;
        localparam int PADDLE     = 6;
        localparam int BORDER     = 7;
        localparam int TOP_LINE   = 4;
        localparam int LEFT_LINE  = 4;
        localparam int RIGHT_LINE = 155;
        localparam int PADDLE_ROW = 115;
        localparam int SPAN       = 10;

        logic       CLOCK_50;
        logic [3:0] KEY;
        logic [7:0] SW;
        logic [7:0] x;
        logic [6:0] y;
        logic [2:0] colour;
        logic       plot;

        // trace columns, one entry per test
        logic [8*24-1:0] t_name [MAX_TESTS];
        logic [8*16-1:0] t_keys [MAX_TESTS];
        int              t_sw [MAX_TESTS];
        int              t_frames [MAX_TESTS];
        int              t_exp [MAX_TESTS][5];
        int              num_tests;
        logic            setup_error;

        // reference model state, index 0 is puck 1
        int   m_paddle;
        int   m_x [2];
        int   m_y [2];
        int   m_vx [2];
        int   m_vy [2];
        logic m_miss;

        logic [8*24-1:0] cur_name;
        int              test_errors;
        int              pass_cnt;
        int              fail_cnt;
        longint          limit_ns;

        pong_top #(
                .loop_speed (LOOP_SPEED)
        ) pong_top_i (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY),
                .SW       (SW),
                .x        (x),
                .y        (y),
                .colour   (colour),
                .plot     (plot)
        );

        always #4 CLOCK_50 = ~CLOCK_50;

        task automatic compare(input string what, input int expected, input int actual);
                if (expected != actual) begin
                        $display("error %0s %0s: expected %0d, actual %0d",
                                 cur_name, what, expected, actual);
                        test_errors++;
                end
        endtask

        // waits for the next plotted pixel, sampled on the falling edge where it is stable
        task automatic expect_pixel(input int ex, input int ey, input int ec);
                @(negedge CLOCK_50);
                while (!plot)
                        @(negedge CLOCK_50);
                compare("x", ex, x);
                compare("y", ey, y);
                compare("colour", ec, colour);
        endtask

        // full clear in raster order, then top, right and left border lines
        task automatic check_setup();
                for (int row = 0; row < 120; row++)
                        for (int col = 0; col < 160; col++)
                                expect_pixel(col, row, BG);
                for (int col = LEFT_LINE; col <= RIGHT_LINE; col++)
                        expect_pixel(col, TOP_LINE, BORDER);
                for (int row = TOP_LINE; row < 120; row++)
                        expect_pixel(RIGHT_LINE, row, BORDER);
                for (int row = TOP_LINE; row < 120; row++)
                        expect_pixel(LEFT_LINE, row, BORDER);
        endtask

        // the puck moves first, then its new position is tested against walls and paddle
        task automatic step_puck(input int p);
                m_x[p] += m_vx[p];
                m_y[p] += m_vy[p];
                if (m_y[p] == TOP_LINE + 1)
                        m_vy[p] = -m_vy[p];
                if (m_x[p] == LEFT_LINE + 1 || m_x[p] == RIGHT_LINE - 1)
                        m_vx[p] = -m_vx[p];
                if (m_y[p] == PADDLE_ROW - 1) begin
                        if (m_x[p] >= m_paddle && m_x[p] <= m_paddle + SPAN)
                                m_vy[p] = -m_vy[p];
                        else
                                m_miss = 1'b1;
                end
        endtask

        // right has priority over left, and a step is taken only if it stays inside
        task automatic move_paddle(input logic [7:0] code);
                if (code == "R" || code == "B") begin
                        if (m_paddle <= RIGHT_LINE - SPAN - 2)
                                m_paddle += 2;
                end else if (code == "L") begin
                        if (m_paddle >= LEFT_LINE + 2)
                                m_paddle -= 2;
                end
        endtask

        // letter for a frame, the last letter of the pattern holds for the rest
        function automatic logic [7:0] key_at(input logic [8*16-1:0] keys, input int frame);
                int len;
                len = 0;
                for (int i = 0; i < 16; i++)
                        if (keys[8*i +: 8] != 8'd0)
                                len++;
                if (frame >= len)
                        return keys[7:0];
                return keys[8*(len-1-frame) +: 8];
        endfunction

        // KEY[0] is right and KEY[1] is left, both pressed when low
        function automatic logic [1:0] key_bits(input logic [7:0] code);
                logic [1:0] bits;
                case (code)
                "R": bits = 2'b10;
                "L": bits = 2'b01;
                "B": bits = 2'b00;
                default: bits = 2'b11;
                endcase
                return bits;
        endfunction

        function automatic logic [7:0] first_char(input logic [8*24-1:0] word);
                logic [7:0] c;
                c = 8'd0;
                for (int i = 0; i < 24; i++)
                        if (word[8*i +: 8] != 8'd0)
                                c = word[8*i +: 8];
                return c;
        endfunction

        // ==================================================
        // trace reader
        // ==================================================
        task automatic read_trace();
                int              fd;
                int              code;
                int              v [7];
                logic [8*24-1:0] tok;
                logic [8*16-1:0] keys;
                logic [8*128-1:0] rest;
                num_tests = 0;
                fd = $fopen("sim/pong_trace.txt", "r");
                if (fd == 0) begin
                        $display("the trace file sim/pong_trace.txt could not be opened");
                        setup_error = 1'b1;
                        return;
                end
                while (!$feof(fd)) begin
                        code = $fscanf(fd, "%s", tok);
                        if (code != 1)
                                continue;
                        if (first_char(tok) == "#") begin
                                code = $fgets(rest, fd);
                                continue;
                        end
                        code = $fscanf(fd, "%d %d %s %d %d %d %d %d", v[0], v[1], keys,
                                       v[2], v[3], v[4], v[5], v[6]);
                        if (code != 8 || num_tests >= MAX_TESTS) begin
                                $display("trace line for %0s is malformed or one too many", tok);
                                setup_error = 1'b1;
                        end else begin
                                t_name[num_tests]   = tok;
                                t_sw[num_tests]     = v[0];
                                t_frames[num_tests] = v[1];
                                t_keys[num_tests]   = keys;
                                for (int i = 0; i < 5; i++)
                                        t_exp[num_tests][i] = v[i+2];
                                num_tests++;
                        end
                end
                $fclose(fd);
        endtask

        // ==================================================
        // one test: reset, setup drawing, then frame by frame
        // ==================================================
        task automatic run_test(input int t);
                logic [7:0] code;
                int         frames_run;
                cur_name    = t_name[t];
                test_errors = 0;
                m_miss      = 1'b0;
                // SW[1] low keeps the centre start, otherwise SW[2] picks the wall
                if ((t_sw[t] & 2) == 0)
                        m_paddle = 75;
                else if ((t_sw[t] & 4) == 0)
                        m_paddle = LEFT_LINE + 1;
                else
                        m_paddle = RIGHT_LINE - SPAN - 1;
                m_x[0]  = 80;
                m_y[0]  = 60;
                m_vx[0] = 1;
                m_vy[0] = -1;
                m_x[1]  = 40;
                m_y[1]  = 60;
                m_vx[1] = -1;
                m_vy[1] = -1;

                @(posedge CLOCK_50);
                KEY <= 4'b0111;
                SW  <= 8'(t_sw[t] & 7);
                repeat (3) @(posedge CLOCK_50);
                KEY <= 4'b1111;
                check_setup();

                frames_run = 0;
                while (frames_run < t_frames[t] && !m_miss) begin
                        code = key_at(t_keys[t], frames_run);
                        // keys are only looked at when the paddle moves, idle noise is harmless
                        @(posedge CLOCK_50);
                        KEY[1:0] <= 2'($urandom);
                        for (int i = 0; i <= SPAN; i++) begin
                                expect_pixel(m_paddle + i, PADDLE_ROW, BG);
                                if (i == 0) begin
                                        @(posedge CLOCK_50);
                                        KEY[1:0] <= key_bits(code);
                                end
                        end
                        move_paddle(code);
                        for (int i = 0; i <= SPAN; i++)
                                expect_pixel(m_paddle + i, PADDLE_ROW, PADDLE);
                        for (int p = 0; p < 2; p++) begin
                                if (!m_miss && (p == 0 || (t_sw[t] & 1) != 0)) begin
                                        expect_pixel(m_x[p], m_y[p], BG);
                                        step_puck(p);
                                        // a lost puck is not drawn
                                        if (!m_miss)
                                                expect_pixel(m_x[p], m_y[p], PUCK);
                                end
                        end
                        frames_run++;
                end

                // a miss restarts with a fresh clear, otherwise the next frame begins
                if (m_miss)
                        check_setup();
                else
                        expect_pixel(m_paddle, PADDLE_ROW, BG);

                compare("frames", t_frames[t], frames_run);
                compare("trace paddle_x", t_exp[t][0], m_paddle);
                compare("trace puck1_x", t_exp[t][1], m_x[0]);
                compare("trace puck1_y", t_exp[t][2], m_y[0]);
                compare("trace puck2_x", t_exp[t][3], m_x[1]);
                compare("trace puck2_y", t_exp[t][4], m_y[1]);

                if (test_errors == 0) begin
                        pass_cnt++;
                        $display("test %0s passed after %0d frames", cur_name, frames_run);
                end else begin
                        fail_cnt++;
                        $display("test %0s failed with %0d errors", cur_name, test_errors);
                end
        endtask

        initial begin
                longint total;
                CLOCK_50    = 1'b0;
                KEY         = 4'b0111;
                SW          = 8'h00;
                setup_error = 1'b0;
                pass_cnt    = 0;
                fail_cnt    = 0;
                limit_ns    = 0;
                void'($urandom(86));
                read_trace();
                total = 0;
                for (int i = 0; i < num_tests; i++)
                        total += longint'(SETUP_CYCLES + t_frames[i] * (LOOP_SPEED + 40)) * 16;
                limit_ns = total;
                for (int i = 0; i < num_tests; i++)
                        run_test(i);
                $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0 && !setup_error && num_tests > 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

        // watchdog, the limit is twice the expected length of all tests
        initial begin
                wait (limit_ns > 0);
                #(limit_ns);
                $display("timeout: the DUT stopped plotting the expected pixels in time");
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

//--- hdl/pong_top.sv
`timescale 1ns/10ps

// game top level, the pixel stream goes straight out to an external frame buffer
module pong_top import pong_pkg::*; #(
        parameter int loop_speed = 6250000
) (
        input  logic       CLOCK_50,
        input  logic [3:0] KEY,
        input  logic [7:0] SW,
        output logic [7:0] x,
        output logic [6:0] y,
        output colour_t    colour,
        output logic       plot
);

        // control pulses from the sequencer
        logic restart;
        logic paddle_move;
        logic step1;
        logic step2;

        // positions fed back to the sequencer
        coord_t paddle_x;
        coord_t puck1_x;
        coord_t puck1_y;
        coord_t puck2_x;
        coord_t puck2_y;
        logic   puck1_miss;
        logic   puck2_miss;

        // full width cursor row, the frame buffer only needs 7 bits of it
        coord_t draw_y;

        // ==================================================
        // frame sequencer
        // ==================================================
        draw_sequencer #(
                .loop_speed (loop_speed)
        ) draw_sequencer_i (
                .CLOCK_50     (CLOCK_50),
                .KEY          (KEY[3]),
                .two_puck_sel (SW[0]),
                .paddle_x     (paddle_x),
                .puck1_x      (puck1_x),
                .puck1_y      (puck1_y),
                .puck1_miss   (puck1_miss),
                .puck2_x      (puck2_x),
                .puck2_y      (puck2_y),
                .puck2_miss   (puck2_miss),
                .restart      (restart),
                .paddle_move  (paddle_move),
                .step1        (step1),
                .step2        (step2),
                .draw_x       (x),
                .draw_y       (draw_y),
                .colour       (colour),
                .plot         (plot)
        );

        assign y = draw_y[6:0];

        // KEY[0] moves right and KEY[1] moves left, both active low
        paddle_control paddle_control_i (
                .CLOCK_50     (CLOCK_50),
                .KEY          (KEY[3]),
                .restart      (restart),
                .start_sel    (SW[1]),
                .start_right  (SW[2]),
                .paddle_move  (paddle_move),
                .move_right_n (KEY[0]),
                .move_left_n  (KEY[1]),
                .paddle_x     (paddle_x)
        );

        // ==================================================
        // the two pucks
        // ==================================================
        puck_motion #(
                .start_x  (80),
                .start_vx (1),
                .start_vy (-1)
        ) puck1_i (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY[3]),
                .restart  (restart),
                .step     (step1),
                .paddle_x (paddle_x),
                .pos_x    (puck1_x),
                .pos_y    (puck1_y),
                .miss     (puck1_miss)
        );

        // the second puck heads up and to the left
        puck_motion #(
                .start_x  (40),
                .start_vx (-1),
                .start_vy (-1)
        ) puck2_i (
                .CLOCK_50 (CLOCK_50),
                .KEY      (KEY[3]),
                .restart  (restart),
                .step     (step2),
                .paddle_x (paddle_x),
                .pos_x    (puck2_x),
                .pos_y    (puck2_y),
                .miss     (puck2_miss)
        );

endmodule

//--- hdl/draw_sequencer.sv
`timescale 1ns/10ps

// frame FSM, it walks the screen clear, the borders and then one frame per delay
module draw_sequencer import pong_pkg::*; #(
        parameter int loop_speed = 6250000
) (
        input  logic    CLOCK_50,
        input  logic    KEY,
        input  logic    two_puck_sel,
        input  coord_t  paddle_x,
        input  coord_t  puck1_x,
        input  coord_t  puck1_y,
        input  logic    puck1_miss,
        input  coord_t  puck2_x,
        input  coord_t  puck2_y,
        input  logic    puck2_miss,
        output logic    restart,
        output logic    paddle_move,
        output logic    step1,
        output logic    step2,
        output coord_t  draw_x,
        output coord_t  draw_y,
        output colour_t colour,
        output logic    plot
);

        // the idle counter runs from 0 to loop_speed, so loop_speed + 1 cycles
        localparam int CNT_W = $clog2(loop_speed + 1);
        localparam logic [CNT_W-1:0] IDLE_LAST = CNT_W'(loop_speed);

        draw_state_t state;

        // cursor, in the paddle states cur_x is the offset into the paddle span
        coord_t cur_x;
        coord_t cur_y;

        logic [CNT_W-1:0] idle_cnt;
        logic             two_puck;

        // ==================================================
        // state and cursor
        // ==================================================
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        state    <= INIT;
                        cur_x    <= '0;
                        cur_y    <= '0;
                        two_puck <= 1'b0;
                end else begin
                        case (state)
                        INIT: begin
                                // the puck count is fixed for the whole game
                                two_puck <= two_puck_sel;
                                cur_x    <= '0;
                                cur_y    <= '0;
                                state    <= CLEAR;
                        end
                        CLEAR: begin
                                // raster order, one pixel per cycle
                                if (cur_x == SCREEN_WIDTH - 8'd1) begin
                                        cur_x <= '0;
                                        if (cur_y == SCREEN_HEIGHT - 8'd1)
                                                state <= TOP_ENTER;
                                        else
                                                cur_y <= cur_y + 8'd1;
                                end else begin
                                        cur_x <= cur_x + 8'd1;
                                end
                        end
                        TOP_ENTER: begin
                                cur_x <= LEFT_LINE;
                                cur_y <= TOP_LINE;
                                state <= TOP_LOOP;
                        end
                        TOP_LOOP: begin
                                if (cur_x == RIGHT_LINE)
                                        state <= RIGHT_ENTER;
                                else
                                        cur_x <= cur_x + 8'd1;
                        end
                        RIGHT_ENTER: begin
                                cur_x <= RIGHT_LINE;
                                cur_y <= TOP_LINE;
                                state <= RIGHT_LOOP;
                        end
                        RIGHT_LOOP: begin
                                if (cur_y == SCREEN_HEIGHT - 8'd1)
                                        state <= LEFT_ENTER;
                                else
                                        cur_y <= cur_y + 8'd1;
                        end
                        LEFT_ENTER: begin
                                cur_x <= LEFT_LINE;
                                cur_y <= TOP_LINE;
                                state <= LEFT_LOOP;
                        end
                        LEFT_LOOP: begin
                                if (cur_y == SCREEN_HEIGHT - 8'd1)
                                        state <= IDLE;
                                else
                                        cur_y <= cur_y + 8'd1;
                        end
                        IDLE: begin
                                if (idle_cnt == IDLE_LAST)
                                        state <= ERASE_PADDLE_ENTER;
                        end
                        ERASE_PADDLE_ENTER: begin
                                cur_x <= '0;
                                state <= ERASE_PADDLE_LOOP;
                        end
                        ERASE_PADDLE_LOOP: begin
                                if (cur_x == PADDLE_WIDTH)
                                        state <= DRAW_PADDLE_ENTER;
                                else
                                        cur_x <= cur_x + 8'd1;
                        end
                        DRAW_PADDLE_ENTER: begin
                                // paddle_x takes its new value at the end of this cycle
                                cur_x <= '0;
                                state <= DRAW_PADDLE_LOOP;
                        end
                        DRAW_PADDLE_LOOP: begin
                                if (cur_x == PADDLE_WIDTH)
                                        state <= ERASE_PUCK1;
                                else
                                        cur_x <= cur_x + 8'd1;
                        end
                        ERASE_PUCK1: state <= DRAW_PUCK1;
                        DRAW_PUCK1: begin
                                // a miss from the step just taken restarts the game
                                if (puck1_miss)
                                        state <= INIT;
                                else if (two_puck)
                                        state <= ERASE_PUCK2;
                                else
                                        state <= IDLE;
                        end
                        ERASE_PUCK2: state <= DRAW_PUCK2;
                        DRAW_PUCK2: begin
                                if (puck2_miss)
                                        state <= INIT;
                                else
                                        state <= IDLE;
                        end
                        default: state <= INIT;
                        endcase
                end
        end

        // frame delay, held at zero outside IDLE so every frame waits the same
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY)
                        idle_cnt <= '0;
                else if (state == IDLE)
                        idle_cnt <= idle_cnt + 1'b1;
                else
                        idle_cnt <= '0;
        end

        // ==================================================
        // control pulses and pixel outputs
        // ==================================================
        assign restart     = (state == INIT);
        assign paddle_move = (state == DRAW_PADDLE_ENTER);
        assign step1       = (state == ERASE_PUCK1);
        assign step2       = (state == ERASE_PUCK2);

        always_comb begin
                plot   = 1'b0;
                colour = BG_COLOUR;
                draw_x = cur_x;
                draw_y = cur_y;
                case (state)
                CLEAR: plot = 1'b1;
                TOP_LOOP, RIGHT_LOOP, LEFT_LOOP: begin
                        plot   = 1'b1;
                        colour = BORDER_COLOUR;
                end
                ERASE_PADDLE_LOOP, DRAW_PADDLE_LOOP: begin
                        // erase uses the old position, draw the moved one
                        plot   = 1'b1;
                        colour = (state == DRAW_PADDLE_LOOP) ? PADDLE_COLOUR : BG_COLOUR;
                        draw_x = paddle_x + cur_x;
                        draw_y = PADDLE_ROW;
                end
                ERASE_PUCK1, DRAW_PUCK1: begin
                        // the puck moves at the end of the erase cycle
                        plot   = (state == ERASE_PUCK1) || !puck1_miss;
                        colour = (state == DRAW_PUCK1) ? PUCK_COLOUR : BG_COLOUR;
                        draw_x = puck1_x;
                        draw_y = puck1_y;
                end
                ERASE_PUCK2, DRAW_PUCK2: begin
                        plot   = (state == ERASE_PUCK2) || !puck2_miss;
                        colour = (state == DRAW_PUCK2) ? PUCK_COLOUR : BG_COLOUR;
                        draw_x = puck2_x;
                        draw_y = puck2_y;
                end
                default: plot = 1'b0;
                endcase
        end

endmodule

//--- hdl/puck_motion.sv
`timescale 1ns/10ps

// one puck with its position and its direction on each axis
module puck_motion import pong_pkg::*; #(
        parameter int start_x  = 80,
        parameter int start_vx = 1,
        parameter int start_vy = -1
) (
        input  logic   CLOCK_50,
        input  logic   KEY,
        input  logic   restart,
        input  logic   step,
        input  coord_t paddle_x,
        output coord_t pos_x,
        output coord_t pos_y,
        output logic   miss
);

        // velocity is always one pixel per step, so only its sign is kept
        localparam logic START_NEG_X = (start_vx < 0);
        localparam logic START_NEG_Y = (start_vy < 0);

        logic   neg_x;
        logic   neg_y;
        coord_t next_x;
        coord_t next_y;
        logic   on_paddle;

        // bounce checks look at the position after the move
        assign next_x    = neg_x ? pos_x - 8'd1 : pos_x + 8'd1;
        assign next_y    = neg_y ? pos_y - 8'd1 : pos_y + 8'd1;
        assign on_paddle = (next_x >= paddle_x) && (next_x <= paddle_x + PADDLE_WIDTH);

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        pos_x <= coord_t'(start_x);
                        pos_y <= FACEOFF_Y;
                        neg_x <= START_NEG_X;
                        neg_y <= START_NEG_Y;
                        miss  <= 1'b0;
                end else if (restart) begin
                        // a new game puts the puck back on the faceoff row
                        pos_x <= coord_t'(start_x);
                        pos_y <= FACEOFF_Y;
                        neg_x <= START_NEG_X;
                        neg_y <= START_NEG_Y;
                        miss  <= 1'b0;
                end else if (step) begin
                        pos_x <= next_x;
                        pos_y <= next_y;
                        if (next_y == TOP_LINE + 8'd1)
                                neg_y <= ~neg_y;
                        if ((next_x == LEFT_LINE + 8'd1) || (next_x == RIGHT_LINE - 8'd1))
                                neg_x <= ~neg_x;
                        // one row above the paddle it either bounces or is lost
                        if (next_y == PADDLE_ROW - 8'd1) begin
                                if (on_paddle)
                                        neg_y <= ~neg_y;
                                else
                                        miss <= 1'b1;
                        end
                end
        end

endmodule

//--- hdl/paddle_control.sv
`timescale 1ns/10ps

// paddle position, placed from the switches and moved once per frame by the keys
module paddle_control import pong_pkg::*; (
        input  logic   CLOCK_50,
        input  logic   KEY,
        input  logic   restart,
        input  logic   start_sel,
        input  logic   start_right,
        input  logic   paddle_move,
        input  logic   move_right_n,
        input  logic   move_left_n,
        output coord_t paddle_x
);

        // furthest positions from which a full step still fits inside the walls
        localparam coord_t RIGHT_LIMIT = RIGHT_LINE - PADDLE_WIDTH - 8'd2;
        localparam coord_t LEFT_LIMIT  = LEFT_LINE + 8'd2;

        coord_t start_pos;

        // SW[1] picks a wall start, SW[2] then chooses which wall
        always_comb begin
                if (!start_sel)
                        start_pos = PADDLE_X_START;
                else if (!start_right)
                        start_pos = LEFT_LINE + 8'd1;
                else
                        start_pos = RIGHT_LINE - PADDLE_WIDTH - 8'd1;
        end

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        paddle_x <= PADDLE_X_START;
                end else if (restart) begin
                        paddle_x <= start_pos;
                end else if (paddle_move) begin
                        // right wins when both keys are held
                        if (!move_right_n) begin
                                if (paddle_x <= RIGHT_LIMIT)
                                        paddle_x <= paddle_x + PADDLE_STEP;
                        end else if (!move_left_n) begin
                                if (paddle_x >= LEFT_LIMIT)
                                        paddle_x <= paddle_x - PADDLE_STEP;
                        end
                end
        end

endmodule

//--- hdl/pong_pkg.sv
// shared types and constants for the paddle game
package pong_pkg;

        // pixel coordinates and the 3-bit colour code of the frame buffer
        typedef logic [7:0] coord_t;
        typedef logic [2:0] colour_t;

        // ==================================================
        // colours
        // ==================================================
        localparam colour_t BG_COLOUR     = 3'd0;
        localparam colour_t PUCK_COLOUR   = 3'd5;
        localparam colour_t PADDLE_COLOUR = 3'd6;
        localparam colour_t BORDER_COLOUR = 3'd7;

        // ==================================================
        // playfield geometry
        // ==================================================
        localparam coord_t SCREEN_WIDTH  = 8'd160;
        localparam coord_t SCREEN_HEIGHT = 8'd120;

        // border lines, the side lines run from the top line to the bottom row
        localparam coord_t TOP_LINE   = 8'd4;
        localparam coord_t LEFT_LINE  = 8'd4;
        localparam coord_t RIGHT_LINE = 8'd155;

        // the paddle spans paddle_x to paddle_x + PADDLE_WIDTH, so 11 pixels
        localparam coord_t PADDLE_ROW     = 8'd115;
        localparam coord_t PADDLE_WIDTH   = 8'd10;
        localparam coord_t PADDLE_X_START = 8'd75;
        localparam coord_t PADDLE_STEP    = 8'd2;

        // both pucks start on this row
        localparam coord_t FACEOFF_Y = 8'd60;

        // sequencer states, ENTER states place the cursor and plot nothing
        typedef enum logic [4:0] {
                INIT,
                CLEAR,
                TOP_ENTER,
                TOP_LOOP,
                RIGHT_ENTER,
                RIGHT_LOOP,
                LEFT_ENTER,
                LEFT_LOOP,
                IDLE,
                ERASE_PADDLE_ENTER,
                ERASE_PADDLE_LOOP,
                DRAW_PADDLE_ENTER,
                DRAW_PADDLE_LOOP,
                ERASE_PUCK1,
                DRAW_PUCK1,
                ERASE_PUCK2,
                DRAW_PUCK2
        } draw_state_t;

endpackage
